/* rtl/stat_pkg.sv */
// Statistics subsystem definitions
`default_nettype none

package stat_pkg;

    // Counter bank geometry
    localparam int stat_id_w = 5;
    localparam int stat_count = 32;

    // Increment word and counter widths
    localparam int stat_inc_w = 16;
    localparam int stat_cnt_w = 64;

    // Host port widths
    localparam int host_addr_w = 8;
    localparam int host_data_w = 32;

    // Register map
    localparam logic [host_addr_w-1:0] reg_ctrl = 8'h00;
    localparam logic [host_addr_w-1:0] reg_status = 8'h01;
    localparam logic [host_addr_w-1:0] reg_clear = 8'h02;

    // Counter window, two words per counter, low word first
    localparam logic [host_addr_w-1:0] reg_cnt_base = 8'h40;

endpackage

`default_nettype wire

/* rtl/stat_arb_mux.sv */
// Round-robin increment stream merge
`timescale 1ns/1ps
`default_nettype none

module stat_arb_mux (
    input  wire logic                            clk,
    input  wire logic                            rst,

    // Source 0
    input  wire logic                            s0_valid,
    input  wire logic [stat_pkg::stat_id_w-1:0]  s0_id,
    input  wire logic [stat_pkg::stat_inc_w-1:0] s0_inc,
    output logic                                 s0_ready,

    // Source 1
    input  wire logic                            s1_valid,
    input  wire logic [stat_pkg::stat_id_w-1:0]  s1_id,
    input  wire logic [stat_pkg::stat_inc_w-1:0] s1_inc,
    output logic                                 s1_ready,

    // Merged output
    output logic                                 m_valid,
    output logic [stat_pkg::stat_id_w-1:0]       m_id,
    output logic [stat_pkg::stat_inc_w-1:0]      m_inc,
    input  wire logic                            m_ready
);

    // High when source 1 won the most recent grant
    logic last_grant;
    logic load;
    logic grant0;
    logic grant1;

    // Output stage can take a word when empty or being drained
    assign load = !m_valid || m_ready;

    // On a tie, the source that lost last time wins
    assign grant0 = s0_valid && (!s1_valid || last_grant);
    assign grant1 = s1_valid && (!s0_valid || !last_grant);

    assign s0_ready = load && grant0;
    assign s1_ready = load && grant1;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            last_grant <= 1'b0;
        end else if (load) begin
            m_valid <= s0_valid || s1_valid;
            if (grant0 || grant1) begin
                last_grant <= grant1;
            end
        end
    end

    // Output word
    always_ff @(posedge clk) begin
        if (s0_ready) begin
            m_id <= s0_id;
            m_inc <= s0_inc;
        end else if (s1_ready) begin
            m_id <= s1_id;
            m_inc <= s1_inc;
        end
    end

    // Only one source is granted per cycle
    a_one_ready: assert property (
        @(posedge clk) disable iff (rst)
        !(s0_ready && s1_ready)
    );

endmodule

`default_nettype wire

/* rtl/stat_counter_ram.sv */
// Statistics counter RAM
`timescale 1ns/1ps
`default_nettype none

module stat_counter_ram (
    input  wire logic                            clk,
    input  wire logic                            rst,

    // Increment stream
    input  wire logic                            in_valid,
    input  wire logic [stat_pkg::stat_id_w-1:0]  in_id,
    input  wire logic [stat_pkg::stat_inc_w-1:0] in_inc,
    output logic                                 in_ready,
    input  wire logic                            count_en,

    // Host counter read
    input  wire logic                            rd,
    input  wire logic [stat_pkg::stat_id_w-1:0]  rd_id,
    input  wire logic                            rd_clear,
    output logic                                 rd_valid,
    output logic [stat_pkg::stat_cnt_w-1:0]      rd_data,

    // Clear sweep
    input  wire logic                            sweep_start,
    output logic                                 sweep_busy
);

    // Counters come up at zero
    logic [stat_pkg::stat_cnt_w-1:0] mem [stat_pkg::stat_count] = '{default: '0};
    logic [stat_pkg::stat_cnt_w-1:0] ram_q;
    logic [stat_pkg::stat_id_w-1:0]  rd_addr;

    // Pending host read
    logic                            rd_pend;
    logic [stat_pkg::stat_id_w-1:0]  rd_pend_id;
    logic                            rd_pend_clear;
    logic                            rd_hazard;
    logic                            rd_go;

    logic                            accept;

    // Read stage
    logic                            s1_valid;
    logic                            s1_clr;
    logic [stat_pkg::stat_id_w-1:0]  s1_id;
    logic [stat_pkg::stat_inc_w-1:0] s1_inc;

    // Add stage
    logic                            s2_valid;
    logic [stat_pkg::stat_id_w-1:0]  s2_id;
    logic [stat_pkg::stat_cnt_w-1:0] s2_sum;

    // Write stage
    logic                            s3_valid;
    logic [stat_pkg::stat_id_w-1:0]  s3_id;
    logic [stat_pkg::stat_cnt_w-1:0] s3_sum;

    logic [stat_pkg::stat_cnt_w-1:0] add_base;
    logic [stat_pkg::stat_id_w-1:0]  sweep_idx;

    // Stream is held off during a sweep and while a host read waits
    assign in_ready = !(sweep_busy || rd_pend);
    assign accept = in_valid && in_ready;

    // A read waits until nothing in flight touches its counter
    assign rd_hazard = (s1_valid && s1_id == rd_pend_id)
                    || (s2_valid && s2_id == rd_pend_id)
                    || (s3_valid && s3_id == rd_pend_id);
    assign rd_go = rd_pend && !sweep_busy && !rd_hazard;

    // Single read port shared by host reads and the accumulate path
    assign rd_addr = rd_go ? rd_pend_id : in_id;
    assign rd_data = ram_q;

    // Newest matching stage wins
    always_comb begin
        if (s2_valid && s2_id == s1_id) begin
            add_base = s2_sum;
        end else if (s3_valid && s3_id == s1_id) begin
            add_base = s3_sum;
        end else begin
            add_base = ram_q;
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_busy) begin
            mem[sweep_idx] <= '0;
        end else if (s3_valid) begin
            mem[s3_id] <= s3_sum;
        end
        // Write-first bypass for the word being stored this edge
        if (s3_valid && s3_id == rd_addr) begin
            ram_q <= s3_sum;
        end else begin
            ram_q <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
            rd_valid <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (rd) begin
                rd_pend <= 1'b1;
            end else if (rd_go) begin
                rd_pend <= 1'b0;
            end
            rd_valid <= rd_go;
            // Clearing read enters the pipeline as a zero write
            s1_valid <= (accept && count_en) || (rd_go && rd_pend_clear);
            s2_valid <= s1_valid && !sweep_busy;
            s3_valid <= s2_valid && !sweep_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rd_pend_id <= rd_id;
            rd_pend_clear <= rd_clear;
        end
        s1_clr <= rd_go;
        s1_id <= rd_addr;
        s1_inc <= in_inc;
        s2_id <= s1_id;
        s2_sum <= s1_clr ? '0 : add_base + stat_pkg::stat_cnt_w'(s1_inc);
        s3_id <= s2_id;
        s3_sum <= s2_sum;
    end

    // Clear sweep, one counter per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_busy <= 1'b0;
            sweep_idx <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == stat_pkg::stat_id_w'(stat_pkg::stat_count - 1)) begin
                sweep_busy <= 1'b0;
            end
        end else if (sweep_start) begin
            sweep_busy <= 1'b1;
            sweep_idx <= '0;
        end
    end

    a_no_accept_in_sweep: assert property (
        @(posedge clk) disable iff (rst)
        sweep_busy |-> !(in_valid && in_ready)
    );

    // Register block waits for the answer before the next read
    a_one_read: assert property (
        @(posedge clk) disable iff (rst)
        rd |-> !rd_pend
    );

endmodule

`default_nettype wire

/* rtl/stat_regs.sv */
// Statistics host registers
`timescale 1ns/1ps
`default_nettype none

module stat_regs (
    input  wire logic                             clk,
    input  wire logic                             rst,

    // Host port
    input  wire logic                             host_wr,
    input  wire logic                             host_rd,
    input  wire logic [stat_pkg::host_addr_w-1:0] host_addr,
    input  wire logic [stat_pkg::host_data_w-1:0] host_wdata,
    output logic [stat_pkg::host_data_w-1:0]      host_rdata,
    output logic                                  host_rvalid,

    // Counter block control
    output logic                                  count_en,
    output logic                                  sweep_start,
    input  wire logic                             sweep_busy,

    // Counter read request
    output logic                                  cnt_rd,
    output logic                                  cnt_rd_clear,
    output logic [stat_pkg::stat_id_w-1:0]        cnt_rd_id,
    input  wire logic                             cnt_rd_valid,
    input  wire logic [stat_pkg::stat_cnt_w-1:0]  cnt_rd_data
);

    logic                             clear_on_rd;
    logic [stat_pkg::host_data_w-1:0] hi_latch;
    logic [stat_pkg::host_addr_w-1:0] cnt_off;
    logic                             cnt_sel;
    logic [stat_pkg::host_data_w-1:0] rd_mux;

    // Offset into the counter window
    assign cnt_off = host_addr - stat_pkg::reg_cnt_base;
    assign cnt_sel = (host_addr >= stat_pkg::reg_cnt_base)
                  && (cnt_off < stat_pkg::host_addr_w'(2 * stat_pkg::stat_count));

    // Immediate read value, counter low words are fetched instead
    always_comb begin
        rd_mux = '0;
        if (cnt_sel) begin
            rd_mux = hi_latch;
        end else begin
            case (host_addr)
                stat_pkg::reg_ctrl: rd_mux[1:0] = {clear_on_rd, count_en};
                stat_pkg::reg_status: rd_mux[0] = sweep_busy;
                default: rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_en <= 1'b1;
            clear_on_rd <= 1'b0;
            sweep_start <= 1'b0;
            cnt_rd <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            sweep_start <= 1'b0;
            cnt_rd <= 1'b0;
            host_rvalid <= 1'b0;
            if (host_wr && host_addr == stat_pkg::reg_ctrl) begin
                count_en <= host_wdata[0];
                clear_on_rd <= host_wdata[1];
            end
            // Any value written here kicks off the sweep
            if (host_wr && host_addr == stat_pkg::reg_clear) begin
                sweep_start <= 1'b1;
            end
            if (host_rd) begin
                if (cnt_sel && !cnt_off[0]) begin
                    cnt_rd <= 1'b1;
                end else begin
                    host_rvalid <= 1'b1;
                end
            end
            if (cnt_rd_valid) begin
                host_rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd) begin
            cnt_rd_id <= cnt_off[stat_pkg::stat_id_w:1];
            cnt_rd_clear <= clear_on_rd;
            host_rdata <= rd_mux;
        end
        // Low word goes out now, high half is kept for the next read
        if (cnt_rd_valid) begin
            host_rdata <= cnt_rd_data[stat_pkg::host_data_w-1:0];
            hi_latch <= cnt_rd_data[stat_pkg::stat_cnt_w-1:stat_pkg::host_data_w];
        end
    end

endmodule

`default_nettype wire

/* rtl/stat_core.sv */
// Statistics collection core
`timescale 1ns/1ps
`default_nettype none

module stat_core (
    input  wire logic                             clk,
    input  wire logic                             rst,

    // Statistics sources
    input  wire logic                             s0_valid,
    input  wire logic [stat_pkg::stat_id_w-1:0]   s0_id,
    input  wire logic [stat_pkg::stat_inc_w-1:0]  s0_inc,
    output logic                                  s0_ready,
    input  wire logic                             s1_valid,
    input  wire logic [stat_pkg::stat_id_w-1:0]   s1_id,
    input  wire logic [stat_pkg::stat_inc_w-1:0]  s1_inc,
    output logic                                  s1_ready,

    // Host port
    input  wire logic                             host_wr,
    input  wire logic                             host_rd,
    input  wire logic [stat_pkg::host_addr_w-1:0] host_addr,
    input  wire logic [stat_pkg::host_data_w-1:0] host_wdata,
    output logic [stat_pkg::host_data_w-1:0]      host_rdata,
    output logic                                  host_rvalid
);

    // Merged stream
    logic                            m_valid;
    logic [stat_pkg::stat_id_w-1:0]  m_id;
    logic [stat_pkg::stat_inc_w-1:0] m_inc;
    logic                            m_ready;

    // Register block to counter block
    logic                            count_en;
    logic                            sweep_start;
    logic                            sweep_busy;
    logic                            cnt_rd;
    logic                            cnt_rd_clear;
    logic [stat_pkg::stat_id_w-1:0]  cnt_rd_id;
    logic                            cnt_rd_valid;
    logic [stat_pkg::stat_cnt_w-1:0] cnt_rd_data;

    stat_arb_mux u_arb (
        .clk      (clk),
        .rst      (rst),
        .s0_valid (s0_valid),
        .s0_id    (s0_id),
        .s0_inc   (s0_inc),
        .s0_ready (s0_ready),
        .s1_valid (s1_valid),
        .s1_id    (s1_id),
        .s1_inc   (s1_inc),
        .s1_ready (s1_ready),
        .m_valid  (m_valid),
        .m_id     (m_id),
        .m_inc    (m_inc),
        .m_ready  (m_ready)
    );

    stat_counter_ram u_cnt (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (m_valid),
        .in_id       (m_id),
        .in_inc      (m_inc),
        .in_ready    (m_ready),
        .count_en    (count_en),
        .rd          (cnt_rd),
        .rd_id       (cnt_rd_id),
        .rd_clear    (cnt_rd_clear),
        .rd_valid    (cnt_rd_valid),
        .rd_data     (cnt_rd_data),
        .sweep_start (sweep_start),
        .sweep_busy  (sweep_busy)
    );

    stat_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .host_wr      (host_wr),
        .host_rd      (host_rd),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_rdata   (host_rdata),
        .host_rvalid  (host_rvalid),
        .count_en     (count_en),
        .sweep_start  (sweep_start),
        .sweep_busy   (sweep_busy),
        .cnt_rd       (cnt_rd),
        .cnt_rd_clear (cnt_rd_clear),
        .cnt_rd_id    (cnt_rd_id),
        .cnt_rd_valid (cnt_rd_valid),
        .cnt_rd_data  (cnt_rd_data)
    );

endmodule

`default_nettype wire

/* verification/stat_ref_model.svh */
// Statistics reference model
`ifndef STAT_REF_MODEL_SVH
`define STAT_REF_MODEL_SVH

// Expected counter values and host register state
logic [63:0] exp_cnt [32];
logic [31:0] exp_hi;
logic        exp_count_en;
logic        exp_clear_on_rd;
logic        exp_busy;

// True when the address falls in the counter window
function automatic logic in_cnt_window(input logic [7:0] addr);
    logic [7:0] off;
    off = addr - stat_pkg::reg_cnt_base;
    return (addr >= stat_pkg::reg_cnt_base) && (off < 8'd64);
endfunction

// Expected host_rdata for a read of addr, before the read takes effect
function automatic logic [31:0] ref_rdata(input logic [7:0] addr);
    logic [7:0] off;
    off = addr - stat_pkg::reg_cnt_base;
    if (in_cnt_window(addr)) begin
        if (off[0]) begin
            return exp_hi;
        end
        return exp_cnt[off[5:1]][31:0];
    end
    case (addr)
        stat_pkg::reg_ctrl: return {30'd0, exp_clear_on_rd, exp_count_en};
        stat_pkg::reg_status: return {31'd0, exp_busy};
        default: return 32'd0;
    endcase
endfunction

// Side effects of a read on the model
task automatic note_read(input logic [7:0] addr);
    logic [7:0] off;
    off = addr - stat_pkg::reg_cnt_base;
    if (in_cnt_window(addr) && !off[0]) begin
        exp_hi = exp_cnt[off[5:1]][63:32];
        if (exp_clear_on_rd) begin
            exp_cnt[off[5:1]] = 64'd0;
        end
    end
endtask

`endif

/* verification/stat_core_tb.sv */
// Statistics core testbench
`timescale 1ns/1ps
`default_nettype none

module stat_core_tb;

    localparam int burst_len = 32800;
    localparam int rand_len = 400;
    // Roughly four times the expected run length
    localparam int cycle_limit = 4 * (2 * burst_len + 2 * rand_len + 2400);

    logic        clk;
    logic        rst;
    logic        s0_valid;
    logic [4:0]  s0_id;
    logic [15:0] s0_inc;
    logic        s0_ready;
    logic        s1_valid;
    logic [4:0]  s1_id;
    logic [15:0] s1_inc;
    logic        s1_ready;
    logic        host_wr;
    logic        host_rd;
    logic [7:0]  host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        host_rvalid;

    integer      seed = 96314;
    int          cycles = 0;
    int          xfer0 = 0;
    int          xfer1 = 0;
    int          issued = 0;
    int          answered = 0;
    int          start;
    logic        fair_on = 1'b0;
    logic [31:0] last_rdata;
    logic [31:0] exp_q [$];
    logic        care_q [$];

    `include "stat_ref_model.svh"

    stat_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    // Stream monitor feeds the model
    always @(posedge clk) begin
        if (!rst) begin
            if (fair_on && s0_valid && s1_valid) begin
                assert (xfer0 - xfer1 <= 1 && xfer1 - xfer0 <= 1)
                else report_error($sformatf("grant imbalance %0d vs %0d", xfer0, xfer1));
            end
            if (s0_valid && s0_ready) begin
                xfer0 <= xfer0 + 1;
                if (exp_count_en) exp_cnt[s0_id] += 64'(s0_inc);
            end
            if (s1_valid && s1_ready) begin
                xfer1 <= xfer1 + 1;
                if (exp_count_en) exp_cnt[s1_id] += 64'(s1_inc);
            end
        end
    end

    // Compares each response with the value captured at issue
    always @(negedge clk) begin
        logic [31:0] exp;
        logic        care;
        if (host_rvalid) begin
            assert (exp_q.size() > 0)
            else report_error("read response arrived with no read outstanding");
            exp = exp_q.pop_front();
            care = care_q.pop_front();
            if (care) begin
                assert (host_rdata === exp)
                else report_error($sformatf("host_rdata %h, expected %h", host_rdata, exp));
            end
            last_rdata = host_rdata;
            answered++;
        end
    end

    task automatic host_read(input logic [7:0] addr, input logic care);
        @(negedge clk);
        exp_q.push_back(ref_rdata(addr));
        care_q.push_back(care);
        note_read(addr);
        host_rd = 1'b1;
        host_addr = addr;
        issued++;
        @(negedge clk);
        host_rd = 1'b0;
        wait (answered == issued);
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        host_wr = 1'b1;
        host_addr = addr;
        host_wdata = data;
        if (addr == stat_pkg::reg_ctrl) begin
            exp_count_en = data[0];
            exp_clear_on_rd = data[1];
        end
        if (addr == stat_pkg::reg_clear) begin
            exp_busy = 1'b1;
            foreach (exp_cnt[i]) exp_cnt[i] = 64'd0;
        end
        @(negedge clk);
        host_wr = 1'b0;
    endtask

    // One word, held until the source sees ready
    task automatic send(input int src, input logic [4:0] id, input logic [15:0] inc);
        @(negedge clk);
        if (src == 0) begin
            s0_valid = 1'b1;
            s0_id = id;
            s0_inc = inc;
        end else begin
            s1_valid = 1'b1;
            s1_id = id;
            s1_inc = inc;
        end
        do @(posedge clk); while (!(src == 0 ? s0_ready : s1_ready));
    endtask

    task automatic release_src(input int src);
        @(negedge clk);
        if (src == 0) s0_valid = 1'b0;
        else s1_valid = 1'b0;
    endtask

    // Burst of full-scale words to one counter, or random words
    task automatic run_source(input int src, input int n, input logic burst);
        logic [4:0]  id;
        logic [15:0] inc;
        for (int i = 0; i < n; i++) begin
            id = burst ? 5'd3 : 5'($random(seed) & 7);
            inc = (burst || ($random(seed) & 3) == 0) ? 16'hffff : 16'($random(seed));
            send(src, id, inc);
        end
        release_src(src);
    endtask

    task automatic check_all();
        for (int i = 0; i < 32; i++) begin
            host_read(stat_pkg::reg_cnt_base + 8'(2 * i), 1'b1);
            host_read(stat_pkg::reg_cnt_base + 8'(2 * i + 1), 1'b1);
        end
    endtask

    task automatic wait_sweep_done();
        do host_read(stat_pkg::reg_status, 1'b0); while (last_rdata[0]);
        exp_busy = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        {s0_valid, s0_id, s0_inc, s1_valid, s1_id, s1_inc} = '0;
        {host_wr, host_rd, host_addr, host_wdata} = '0;
        foreach (exp_cnt[i]) exp_cnt[i] = 64'd0;
        exp_hi = 32'd0;
        {exp_count_en, exp_clear_on_rd, exp_busy} = 3'b100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Single increments
        fork
            begin send(0, 5'd5, 16'h0012); release_src(0); end
            begin send(1, 5'd9, 16'h0345); release_src(1); end
        join
        check_all();

        // Saturating burst on one counter, both sources, fairness watched
        fair_on = 1'b1;
        fork
            run_source(0, burst_len, 1'b1);
            run_source(1, burst_len, 1'b1);
        join
        fair_on = 1'b0;

        // Random concurrent traffic with repeated indexes
        fork
            run_source(0, rand_len, 1'b0);
            run_source(1, rand_len, 1'b0);
        join
        check_all();

        // Counting disabled, then enabled again
        host_write(stat_pkg::reg_ctrl, 32'h0);
        host_read(stat_pkg::reg_ctrl, 1'b1);
        fork
            run_source(0, 50, 1'b0);
            run_source(1, 50, 1'b0);
        join
        check_all();
        host_write(stat_pkg::reg_ctrl, 32'h1);
        fork
            run_source(0, 50, 1'b0);
            run_source(1, 50, 1'b0);
        join
        check_all();

        // Clear-on-read, then the clear sweep
        host_write(stat_pkg::reg_ctrl, 32'h3);
        host_read(stat_pkg::reg_cnt_base + 8'd6, 1'b1);
        host_read(stat_pkg::reg_cnt_base + 8'd7, 1'b1);
        host_read(stat_pkg::reg_cnt_base + 8'd6, 1'b1);
        host_write(stat_pkg::reg_ctrl, 32'h1);
        host_write(stat_pkg::reg_clear, 32'h0);
        host_read(stat_pkg::reg_status, 1'b1);
        wait_sweep_done();
        check_all();

        // Stream stalls during a sweep
        host_write(stat_pkg::reg_clear, 32'h5a);
        host_read(stat_pkg::reg_status, 1'b1);
        start = xfer0;
        @(negedge clk);
        s0_valid = 1'b1;
        s0_id = 5'd7;
        s0_inc = 16'd5;
        repeat (6) @(negedge clk);
        // Only the word parked in the arbiter gets through
        assert (xfer0 - start <= 1 && !s0_ready)
        else report_error("stream accepted words during the sweep");
        host_read(stat_pkg::reg_status, 1'b1);
        wait (xfer0 - start == 2);
        release_src(0);
        wait_sweep_done();
        check_all();
        host_read(8'h03, 1'b1);
        host_read(8'h20, 1'b1);
        host_read(8'h80, 1'b1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verification
rtl/stat_pkg.sv
rtl/stat_arb_mux.sv
rtl/stat_counter_ram.sv
rtl/stat_regs.sv
rtl/stat_core.sv
verification/stat_core_tb.sv
